// File: list.f
+incdir+bench
hw/cpu_pkg.sv
hw/alu.sv
hw/stack.sv
hw/control_unit.sv
hw/cpu_core.sv
hw/cdtimer.sv
hw/bus_decoder.sv
hw/stack_cpu_top.sv
bench/clock_gen.sv
bench/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0 --Wno-fatal
TOP       ?= tb_top
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build products"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^=== PASS ===$$"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/isa_model.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

`default_nettype none

// Architectural state of the reference model
logic [15:0] m_ip;
logic [15:0] m_fp;
logic [15:0] m_tmr;
logic [15:0] m_stk [DEPTH];
logic [15:0] m_cstk [DEPTH];
// Data access still owed on the external port
logic        pend;
logic        pend_we;
logic [11:0] pend_adr;
logic [1:0]  pend_sel;
logic [15:0] pend_dat;
logic        pend_bound;
// Top of stack came from the timer, so only an upper bound is known
logic        tmr_top;

function automatic logic [15:0] alu_ref(input logic [5:0] op, input logic [15:0] a,
                                        input logic [15:0] b);
  logic [15:0] r;
  r = a;
  case (op)
    6'h01: r = a + 16'd1;
    6'h02: r = a + 16'd2;
    6'h04: r = ~a;
    6'h0f: r = b;
    6'h10: r = a & b;
    6'h11: r = a | b;
    6'h12: r = a ^ b;
    6'h14: r = (b > 16'd15) ? 16'd0 : a >> b[3:0];
    6'h15: begin
      // Arithmetic shift one step at a time
      for (int i = 0; i < 16; i++) begin
        if (i < b) begin
          r = {r[15], r[15:1]};
        end
      end
    end
    6'h16: r = (b > 16'd15) ? 16'd0 : a << b[3:0];
    6'h17: r = {a[15:8] | b[7:0], a[7:0]};
    6'h20: r = a + b;
    6'h21: r = a - b;
    6'h22: r = a * b;
    6'h28: r = ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
    6'h29: r = (a == b) ? 16'd1 : 16'd0;
    6'h2a: r = (a != b) ? 16'd1 : 16'd0;
    default: r = a;
  endcase
  return r;
endfunction

task automatic model_reset();
  m_ip    = 16'h0300;
  m_fp    = '0;
  m_tmr   = '0;
  pend    = 1'b0;
  tmr_top = 1'b0;
  for (int i = 0; i < DEPTH; i++) begin
    m_stk[i]  = '0;
    m_cstk[i] = '0;
  end
endtask

task automatic spush(input logic [15:0] v);
  for (int i = DEPTH - 1; i > 0; i--) begin
    m_stk[i] = m_stk[i-1];
  end
  m_stk[0] = v;
endtask

// Bottom refills with zero
task automatic spop();
  for (int i = 0; i < DEPTH - 1; i++) begin
    m_stk[i] = m_stk[i+1];
  end
  m_stk[DEPTH-1] = '0;
endtask

task automatic cpush(input logic [15:0] v);
  for (int i = DEPTH - 1; i > 0; i--) begin
    m_cstk[i] = m_cstk[i-1];
  end
  m_cstk[0] = v;
endtask

task automatic cpop();
  for (int i = 0; i < DEPTH - 1; i++) begin
    m_cstk[i] = m_cstk[i+1];
  end
  m_cstk[DEPTH-1] = '0;
endtask

// Internal space reads zero except the timer
task automatic load_data(input logic [11:0] a, input logic byt, output logic [15:0] v);
  logic [15:0] w;
  if (a <= 12'h07f) begin
    v       = (a == 12'h002) ? m_tmr : 16'h0000;
    tmr_top = (a == 12'h002);
  end else begin
    w        = mem[a[11:1]];
    v        = !byt ? w : (a[0] ? {8'h00, w[15:8]} : {8'h00, w[7:0]});
    pend     = 1'b1;
    pend_we  = 1'b0;
    pend_adr = a;
    pend_sel = !byt ? 2'b11 : (a[0] ? 2'b10 : 2'b01);
  end
endtask

task automatic store_data(input logic [11:0] a, input logic byt, input logic [15:0] v,
                          input logic bound);
  if (a <= 12'h07f) begin
    if (a == 12'h002) begin
      m_tmr = v;
    end
  end else begin
    pend       = 1'b1;
    pend_we    = 1'b1;
    pend_adr   = a;
    pend_bound = bound;
    pend_sel   = !byt ? 2'b11 : (a[0] ? 2'b10 : 2'b01);
    pend_dat   = !byt ? v : (a[0] ? {v[7:0], 8'h00} : {8'h00, v[7:0]});
  end
endtask

task automatic exec_insn(input logic [15:0] w);
  logic [15:0] ipn, base, a, v, r;
  logic        was_tmr;
  ipn        = m_ip + 16'd2;
  m_ip       = ipn;
  pend       = 1'b0;
  pend_bound = 1'b0;
  was_tmr    = tmr_top;
  tmr_top    = 1'b0;
  // X field, zero means offset alone
  case (w[11:10])
    2'd1:    base = m_fp;
    2'd2:    base = ipn;
    2'd3:    base = m_cstk[0];
    default: base = 16'h0000;
  endcase
  if (w[15]) begin
    spush({1'b0, w[14:0]});
  end else begin
    case (w[14:12])
      3'd0: begin
        if (w[0]) begin
          cpush(ipn);
        end
        m_ip = ipn + {{4{w[11]}}, w[11:1], 1'b0} - 16'd2;
      end
      3'd1: begin
        // JZ on zero, JNZ on nonzero
        r = ((m_stk[0] == 16'd0) ^ w[0]) ? ipn + {{4{w[11]}}, w[11:1], 1'b0} - 16'd2 : ipn;
        spop();
        m_ip = r;
      end
      3'd2: begin
        a = base + {{6{w[9]}}, w[9:1], 1'b0};
        load_data(a[11:0], 1'b0, v);
        spush(v);
      end
      3'd3: begin
        a = base + {{6{w[9]}}, w[9:1], 1'b0};
        v = m_stk[0];
        spop();
        store_data(a[11:0], 1'b0, v, was_tmr);
      end
      3'd4: spush(base + {{6{w[9]}}, w[9:0]});
      3'd5: begin
        if (w[11:10] == 2'd0) begin
          m_fp = m_fp + {{6{w[9]}}, w[9:0]};
        end
      end
      3'd7: begin
        if (!w[11]) begin
          r = alu_ref(w[5:0], m_stk[0], m_stk[1]);
          if (w[7]) begin
            spush(r);
          end else if (w[6]) begin
            spop();
            m_stk[0] = r;
          end else begin
            m_stk[0] = r;
          end
        end else begin
          case (w[3:0])
            4'h0: begin
              m_ip = m_cstk[0];
              cpop();
            end
            4'h2: begin
              m_fp = m_cstk[0];
              cpop();
            end
            4'h3: cpush(m_fp);
            4'h8, 4'h9: begin
              load_data(m_stk[0][11:0], w[0], v);
              m_stk[0] = v;
            end
            4'hc, 4'hd, 4'he, 4'hf: begin
              // STA keeps the address, STD keeps the value
              a = m_stk[0];
              v = m_stk[1];
              spop();
              if (!w[1]) begin
                m_stk[0] = a;
              end
              store_data(a[11:0], w[0], v, 1'b0);
            end
            default: ;
          endcase
        end
      end
      default: ;
    endcase
  end
endtask

`default_nettype wire

`endif

// File: bench/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;

  localparam int DEPTH   = 8;
  localparam int TIMEOUT = 40000;

  logic             clk, rst;
  cpu_pkg::wb_req_t ext_req, held;
  cpu_pkg::wb_rsp_t ext_rsp;
  logic [15:0]      mem [2048];
  logic [15:0]      rdat;
  logic [11:0]      end_adr;
  logic [5:0]       ops [18];
  integer           seed;
  int               err_data, err_proto, end_hits, gpc, gd, gfp, wait_cnt, n;
  logic             waiting;

  `include "isa_model.svh"

  clock_gen i_clock_gen (
    .clk (clk),
    .rst (rst)
  );

  stack_cpu_top #(
    .STACK_DEPTH (DEPTH),
    .TICK_CYCLES (27)
  ) i_dut (
    .clk     (clk),
    .rst     (rst),
    .ext_req (ext_req),
    .ext_rsp (ext_rsp)
  );

  function automatic int pick(input int lo, input int hi);
    int unsigned r;
    r = $random(seed);
    return lo + int'(r % (hi - lo + 1));
  endfunction

  // Opcode base, X field and offset field
  function automatic logic [15:0] enc(input logic [15:0] op, input int x, input int off);
    logic [15:0] o;
    o = 16'(off);
    return op | 16'(x << 10) | (o & 16'h03ff);
  endfunction

  task automatic emit(input logic [15:0] w);
    mem[gpc] = w;
    gpc++;
  endtask

  // Word store to 100h..1FEh with no base
  task automatic emit_st0();
    emit(enc(16'h3000, 0, pick(16'h080, 16'h0ff) * 2));
    gd--;
  endtask

  task automatic gen_program();
    int lo, ipn, b;
    gpc = 16'h0180;
    emit(16'h5100);
    emit(16'h5100);
    gfp = 16'h0200;
    for (gd = 0; gd < 3; ) begin
      emit(16'h8000 | 16'(pick(0, 32767)));
      gd++;
    end
    while (gpc < 16'h0180 + 200) begin
      case (pick(0, 11))
        0: if (gd < 7) begin
          emit(16'h8000 | 16'(pick(0, 32767)));
          gd++;
        end
        1: begin
          lo = (gd <= 6) ? pick(0, 1) : 0;
          b  = (gd >= 2) ? pick(0, 1) : 0;
          emit(16'h7000 | 16'(lo << 7) | 16'(b << 6) | 16'(ops[pick(0, 17)]));
          gd += lo ? 1 : (b ? -1 : 0);
          if (gd >= 2 && pick(0, 1)) begin
            emit_st0();
          end
        end
        2: if (gd >= 2) begin
          emit_st0();
        end
        3: if (gd <= 6) begin
          // LD fp relative or absolute, then ST ip relative
          if (pick(0, 1)) begin
            emit(enc(16'h2000, 1, pick(-64, 63) * 2));
          end else begin
            emit(enc(16'h2000, 0, pick(16'h080, 16'h0ff) * 2));
          end
          ipn = gpc * 2 + 2;
          lo  = (ipn - 16'h200 > 16'h100) ? ipn - 16'h200 : 16'h100;
          emit(enc(16'h3000, 2, pick(lo / 2, 16'h17f) * 2 - ipn));
        end
        4: if (gd <= 6) begin
          emit(enc(16'h4000, pick(0, 3), pick(-512, 511)));
          emit(enc(16'h3000, 1, pick(-64, 63) * 2));
        end
        5: begin
          b = pick(-32, 32) * 2;
          if (gfp + b >= 16'h180 && gfp + b <= 16'h280) begin
            emit(enc(16'h5000, 0, b));
            gfp += b;
          end
        end
        6: if (gd <= 6) begin
          b = pick(0, 1);
          emit(16'h8000 | 16'(b ? pick(16'h100, 16'h2ff) : pick(16'h80, 16'h17f) * 2));
          emit(16'h7808 | 16'(b));
          gd++;
          emit_st0();
        end
        7: if (gd <= 5) begin
          b = pick(0, 1);
          emit(16'h8000 | 16'(pick(0, 32767)));
          emit(16'h8000 | 16'(b ? pick(16'h100, 16'h2ff) : pick(16'h80, 16'h17f) * 2));
          emit(16'h780c | 16'(pick(0, 1) << 1) | 16'(b));
          gd++;
          emit_st0();
        end
        8: if (gd <= 6) begin
          // Taken branch skips the NOP
          emit(16'h8000 | 16'(pick(0, 1) ? pick(1, 32767) : 0));
          emit(16'h1004 | 16'(pick(0, 1)));
          emit(16'h7000);
        end
        9: begin
          emit(16'h0005);
          emit(16'h0004);
          emit(16'h7800);
        end
        10: if (gd <= 6) begin
          emit(16'h7803);
          emit(enc(16'h2000, 3, pick(-64, 63) * 2));
          emit(enc(16'h3000, 3, pick(-64, 63) * 2));
          emit(16'h7802);
        end
        default: if (gd <= 6) begin
          // Timer write and readback, then an unmapped read
          emit(16'h8000 | 16'(pick(0, 32767)));
          emit(16'h3002);
          emit(16'h2002);
          emit(enc(16'h3000, 0, pick(16'h080, 16'h0ff) * 2));
          emit(16'h2010);
          emit(enc(16'h3000, 0, pick(16'h080, 16'h0ff) * 2));
        end
      endcase
    end
    end_adr = 12'(gpc * 2);
    emit(16'h0000);
  endtask

  // Check one external access and serve it from the memory array
  task automatic serve(input cpu_pkg::wb_req_t q, output logic [15:0] d);
    logic [15:0] m;
    if (pend) begin
      if (q.we !== pend_we || q.adr !== pend_adr) begin
        $display("FAILED %0t: data access we=%0b adr=%h, model we=%0b adr=%h",
                 $time, q.we, q.adr, pend_we, pend_adr);
        err_data++;
      end
      if (q.sel !== pend_sel) begin
        $display("FAILED %0t: data sel %b, model %b", $time, q.sel, pend_sel);
        err_data++;
      end else if (q.we) begin
        m = {{8{pend_sel[1]}}, {8{pend_sel[0]}}};
        if (pend_bound ? (q.dat > pend_dat) : ((q.dat & m) !== (pend_dat & m))) begin
          $display("FAILED %0t: store data %h at %h, model %h", $time, q.dat, q.adr, pend_dat);
          err_data++;
        end
      end
      if (q.we) begin
        if (q.sel[0]) begin
          mem[q.adr[11:1]][7:0] = q.dat[7:0];
        end
        if (q.sel[1]) begin
          mem[q.adr[11:1]][15:8] = q.dat[15:8];
        end
      end
      pend = 1'b0;
      d    = mem[q.adr[11:1]];
    end else begin
      if (q.we) begin
        $display("Unexpected write to %h where the model expects a fetch", q.adr);
        err_proto++;
      end
      if (q.adr !== m_ip[11:0]) begin
        $display("FAILED %0t: fetch from %h, model ip %h", $time, q.adr, m_ip);
        err_data++;
      end
      d = mem[q.adr[11:1]];
      if (q.adr == end_adr) begin
        end_hits++;
      end
      exec_insn(d);
    end
  endtask

  // Wishbone slave with 0 to 3 wait cycles
  always @(posedge clk) begin
    if (rst) begin
      ext_rsp <= '0;
      waiting = 1'b0;
    end else begin
      ext_rsp.ack <= 1'b0;
      if (ext_req.cyc && ext_req.adr <= 12'h07f) begin
        $display("Internal address %h appeared on the external port", ext_req.adr);
        err_proto++;
      end
      if (ext_req.cyc && ext_req.stb && !ext_rsp.ack) begin
        if (!waiting) begin
          waiting  = 1'b1;
          wait_cnt = pick(0, 3);
          held     = ext_req;
        end else if (ext_req !== held) begin
          $display("Request changed while waiting for ack at %0t", $time);
          err_proto++;
        end
        if (wait_cnt == 0) begin
          serve(ext_req, rdat);
          ext_rsp.ack <= 1'b1;
          ext_rsp.dat <= rdat;
          waiting = 1'b0;
        end else begin
          wait_cnt--;
        end
      end
    end
  end

  initial begin
    ext_rsp   = '0;
    seed      = 32'h69f5_1822;
    err_data  = 0;
    err_proto = 0;
    end_hits  = 0;
    waiting   = 1'b0;
    ops = '{6'h00, 6'h01, 6'h02, 6'h04, 6'h0f, 6'h10, 6'h11, 6'h12, 6'h14,
            6'h15, 6'h16, 6'h17, 6'h20, 6'h21, 6'h22, 6'h28, 6'h29, 6'h2a};
    // Fill depends on the whole word address
    for (int i = 0; i < 2048; i++) begin
      mem[i] = 16'(i * 40503) ^ 16'h5ac3;
    end
    gen_program();
    model_reset();
    for (n = 0; n < 20 && rst !== 1'b0; n++) begin
      @(posedge clk);
    end
    if (rst !== 1'b0) begin
      $display("Reset never released");
      err_proto++;
    end
    for (n = 0; n < TIMEOUT && end_hits < 3; n++) begin
      @(posedge clk);
    end
    if (end_hits < 3) begin
      $display("Timeout after %0d cycles before the final loop was reached", n);
      err_proto++;
    end
    $display("errors: %0d value, %0d other", err_data, err_proto);
    if (err_data + err_proto == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
  output logic clk,
  output logic rst
);

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Reset held for two rising edges
  initial begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

// File: hw/stack_cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module stack_cpu_top #(
  parameter int STACK_DEPTH = 8,
  parameter int TICK_CYCLES = 27
) (
  input  logic             clk,
  input  logic             rst,
  output cpu_pkg::wb_req_t ext_req,
  input  cpu_pkg::wb_rsp_t ext_rsp
);

  cpu_pkg::wb_req_t core_req, int_req;
  cpu_pkg::wb_rsp_t core_rsp, int_rsp;

  cpu_core #(
    .STACK_DEPTH (STACK_DEPTH)
  ) i_cpu_core (
    .clk     (clk),
    .rst     (rst),
    .bus_req (core_req),
    .bus_rsp (core_rsp)
  );

  bus_decoder i_bus_decoder (
    .master_req (core_req),
    .master_rsp (core_rsp),
    .int_req    (int_req),
    .int_rsp    (int_rsp),
    .ext_req    (ext_req),
    .ext_rsp    (ext_rsp),
    .clk        (clk),
    .rst        (rst)
  );

  // Countdown timer at 002h
  cdtimer #(
    .TICK_CYCLES (TICK_CYCLES)
  ) i_cdtimer (
    .clk (clk),
    .rst (rst),
    .req (int_req),
    .rsp (int_rsp)
  );

endmodule

`default_nettype wire

// File: hw/bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module bus_decoder (
  input  cpu_pkg::wb_req_t master_req,
  output cpu_pkg::wb_rsp_t master_rsp,
  output cpu_pkg::wb_req_t int_req,
  input  cpu_pkg::wb_rsp_t int_rsp,
  output cpu_pkg::wb_req_t ext_req,
  input  cpu_pkg::wb_rsp_t ext_rsp,
  input  logic             clk,
  input  logic             rst
);

  logic is_int, is_timer, unm_sel, unm_ack;

  assign is_int   = master_req.adr <= cpu_pkg::INTERNAL_LIMIT;
  assign is_timer = master_req.adr == cpu_pkg::TIMER_ADDR;

  // Unselected slave never sees cyc or stb
  always_comb begin
    ext_req     = master_req;
    ext_req.cyc = master_req.cyc & ~is_int;
    ext_req.stb = master_req.stb & ~is_int;
    int_req     = master_req;
    int_req.cyc = master_req.cyc & is_timer;
    int_req.stb = master_req.stb & is_timer;
  end

  // Unmapped internal space, read as zero and ack one cycle later
  assign unm_sel = master_req.cyc & master_req.stb & is_int & ~is_timer;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      unm_ack <= 1'b0;
    end else begin
      unm_ack <= unm_sel & ~unm_ack;
    end
  end

  always_comb begin
    if (!is_int) begin
      master_rsp = ext_rsp;
    end else if (is_timer) begin
      master_rsp = int_rsp;
    end else begin
      master_rsp = '{dat: 16'h0000, ack: unm_ack};
    end
  end

endmodule

`default_nettype wire

// File: hw/cdtimer.sv
`timescale 1ns/1ps
`default_nettype none

module cdtimer #(
  parameter int TICK_CYCLES = 27
) (
  input  logic             clk,
  input  logic             rst,
  input  cpu_pkg::wb_req_t req,
  output cpu_pkg::wb_rsp_t rsp
);

  localparam int PW = $clog2(TICK_CYCLES + 1);

  logic [PW-1:0] presc;
  logic [15:0]   count;
  logic          ack_q, hit, tick;

  // Decoder only raises stb here for the timer address
  assign hit  = req.cyc & req.stb & ~ack_q;
  assign tick = (presc == PW'(TICK_CYCLES - 1));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      presc <= '0;
      count <= '0;
      ack_q <= 1'b0;
    end else begin
      presc <= tick ? '0 : presc + 1'b1;
      ack_q <= hit;
      // A write wins over the tick, count holds at zero
      if (hit && req.we) begin
        count <= req.dat;
      end else if (tick && count != 16'd0) begin
        count <= count - 16'd1;
      end
    end
  end

  assign rsp = '{dat: count, ack: ack_q};

endmodule

`default_nettype wire

// File: hw/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core #(
  parameter int STACK_DEPTH = 8
) (
  input  logic             clk,
  input  logic             rst,
  output cpu_pkg::wb_req_t bus_req,
  input  cpu_pkg::wb_rsp_t bus_rsp
);

  cpu_pkg::ctrl_t ctrl;
  logic [15:0] ip, fp, insn;
  logic [15:0] imm_mask, imm_val;
  logic [15:0] src_a, src_b, alu_out, stack_in;
  logic [15:0] stack0, stack1, cstack0;
  logic [15:0] rd_fmt, wr_word;
  logic [cpu_pkg::ADDR_WIDTH-1:0] adr;
  logic imm_sign, bus_cyc, bus_fetch;

  // Top bit of the field is its sign, PUSH uimm15 stays unsigned
  // Word offsets keep bit 0 clear when negative
  assign imm_sign = ~insn[15] & |(insn & imm_mask & ~(imm_mask >> 1));
  assign imm_val  = (insn & imm_mask) | ({16{imm_sign}} & ~imm_mask & 16'hfffe);

  always_comb begin
    case (ctrl.src_a)
      cpu_pkg::SRC_FP:   src_a = fp;
      cpu_pkg::SRC_IP:   src_a = ip;
      cpu_pkg::SRC_CSTK: src_a = cstack0;
      default:           src_a = stack0;
    endcase
  end

  assign src_b = ctrl.imm ? imm_val : stack1;

  alu i_alu (
    .a    (src_a),
    .b    (src_b),
    .cond (stack0 != 16'd0),
    .op   (ctrl.alu_op),
    .out  (alu_out)
  );

  stack #(
    .STACK_DEPTH (STACK_DEPTH)
  ) operand_stack (
    .clk     (clk),
    .rst     (rst),
    .pop     (ctrl.pop),
    .push    (ctrl.push),
    .load    (ctrl.load_stk),
    .data_in (stack_in),
    .data0   (stack0),
    .data1   (stack1)
  );

  // CALL pushes ip and CPUSH pushes fp, both through src_a
  stack #(
    .STACK_DEPTH (STACK_DEPTH)
  ) call_stack (
    .clk     (clk),
    .rst     (rst),
    .pop     (ctrl.cpop),
    .push    (ctrl.cpush),
    .load    (ctrl.cpush),
    .data_in (src_a),
    .data0   (cstack0),
    .data1   ()
  );

  control_unit i_control_unit (
    .clk       (clk),
    .rst       (rst),
    .insn      (insn),
    .ack       (bus_rsp.ack),
    .ctrl      (ctrl),
    .imm_mask  (imm_mask),
    .bus_cyc   (bus_cyc),
    .bus_fetch (bus_fetch)
  );

  // Address stays stable for the whole access, so adr[0] picks the lane
  assign adr = bus_fetch ? ip[cpu_pkg::ADDR_WIDTH-1:0] : alu_out[cpu_pkg::ADDR_WIDTH-1:0];

  // Byte reads are zero extended from the addressed lane
  always_comb begin
    if (!ctrl.byt) begin
      rd_fmt = bus_rsp.dat;
    end else if (adr[0]) begin
      rd_fmt = {8'h00, bus_rsp.dat[15:8]};
    end else begin
      rd_fmt = {8'h00, bus_rsp.dat[7:0]};
    end
  end

  assign stack_in = ctrl.rd_mem ? rd_fmt : alu_out;
  assign wr_word  = ctrl.wr_stk1 ? stack1 : stack0;

  always_comb begin
    bus_req     = '0;
    bus_req.cyc = bus_cyc;
    bus_req.stb = bus_cyc;
    bus_req.we  = ctrl.wr_mem;
    bus_req.adr = adr;
    if (!ctrl.byt) begin
      bus_req.sel = 2'b11;
      bus_req.dat = wr_word;
    end else if (adr[0]) begin
      // Odd byte lives in the upper lane
      bus_req.sel = 2'b10;
      bus_req.dat = {wr_word[7:0], 8'h00};
    end else begin
      bus_req.sel = 2'b01;
      bus_req.dat = {8'h00, wr_word[7:0]};
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ip   <= cpu_pkg::RESET_IP;
      fp   <= '0;
      insn <= '0;
    end else begin
      if (ctrl.load_ip) begin
        ip <= alu_out;
      end
      if (ctrl.load_fp) begin
        fp <= alu_out;
      end
      if (ctrl.load_insn) begin
        insn <= bus_rsp.dat;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit (
  input  logic           clk,
  input  logic           rst,
  input  logic [15:0]    insn,
  input  logic           ack,
  output cpu_pkg::ctrl_t ctrl,
  output logic [15:0]    imm_mask,
  output logic           bus_cyc,
  output logic           bus_fetch
);

  // Idle gives the bus its low cycle after a memory access
  typedef enum logic [1:0] {
    S_IDLE,
    S_FETCH,
    S_EXEC,
    S_MEM
  } state_t;

  state_t            state;
  cpu_pkg::ctrl_t    dec;
  cpu_pkg::src_a_t   x_sel;
  cpu_pkg::alu_op_t  addr_op;
  logic              is_mem;
  logic              upd;

  // X = 0 means no base, so the address is the offset alone
  assign x_sel   = cpu_pkg::src_a_t'(insn[11:10]);
  assign addr_op = (x_sel == cpu_pkg::SRC_STK0) ? cpu_pkg::ALU_PASS_B : cpu_pkg::ALU_ADD;

  // Decode of the fetched instruction
  always_comb begin
    dec      = '0;
    is_mem   = 1'b0;
    imm_mask = 16'h0000;
    if (insn[15]) begin
      // PUSH uimm15
      dec.imm      = 1'b1;
      imm_mask     = 16'h7fff;
      dec.alu_op   = cpu_pkg::ALU_PASS_B;
      dec.push     = 1'b1;
      dec.load_stk = 1'b1;
    end else begin
      case (insn[14:12])
        3'b000, 3'b001: begin
          // JMP, CALL, JZ, JNZ
          dec.imm     = 1'b1;
          imm_mask    = 16'h0ffe;
          dec.src_a   = cpu_pkg::SRC_IP;
          dec.load_ip = 1'b1;
          if (insn[12]) begin
            dec.alu_op = insn[0] ? cpu_pkg::ALU_BRNZ : cpu_pkg::ALU_BRZ;
            dec.pop    = 1'b1;
          end else begin
            dec.alu_op = cpu_pkg::ALU_BR;
            // Return address comes from src_a
            dec.cpush  = insn[0];
          end
        end
        3'b010, 3'b011: begin
          // LD and ST, word aligned offset
          dec.imm    = 1'b1;
          imm_mask   = 16'h03fe;
          dec.src_a  = x_sel;
          dec.alu_op = addr_op;
          is_mem     = 1'b1;
          if (insn[12]) begin
            dec.pop    = 1'b1;
            dec.wr_mem = 1'b1;
          end else begin
            dec.push     = 1'b1;
            dec.load_stk = 1'b1;
            dec.rd_mem   = 1'b1;
          end
        end
        3'b100: begin
          // PUSH X+simm10
          dec.imm      = 1'b1;
          imm_mask     = 16'h03ff;
          dec.src_a    = x_sel;
          dec.alu_op   = addr_op;
          dec.push     = 1'b1;
          dec.load_stk = 1'b1;
        end
        3'b101: begin
          // ADD FP, other encodings here are reserved
          if (insn[11:10] == 2'b00) begin
            dec.imm     = 1'b1;
            imm_mask    = 16'h03ff;
            dec.src_a   = cpu_pkg::SRC_FP;
            dec.alu_op  = cpu_pkg::ALU_ADD;
            dec.load_fp = 1'b1;
          end
        end
        3'b111: begin
          if (!insn[11]) begin
            // Stack ALU format
            dec.alu_op   = cpu_pkg::alu_op_t'(insn[5:0]);
            dec.push     = insn[7];
            dec.pop      = insn[6];
            dec.load_stk = 1'b1;
          end else begin
            dec.alu_op = cpu_pkg::ALU_PASS_A;
            dec.byt    = insn[0];
            casez (insn[3:0])
              4'b0000: begin
                dec.src_a   = cpu_pkg::SRC_CSTK;
                dec.load_ip = 1'b1;
                dec.cpop    = 1'b1;
              end
              4'b0010: begin
                dec.src_a   = cpu_pkg::SRC_CSTK;
                dec.load_fp = 1'b1;
                dec.cpop    = 1'b1;
              end
              4'b0011: begin
                dec.src_a = cpu_pkg::SRC_FP;
                dec.cpush = 1'b1;
              end
              4'b100?: begin
                // LDD replaces the address with the data
                dec.load_stk = 1'b1;
                dec.rd_mem   = 1'b1;
                is_mem       = 1'b1;
              end
              4'b11??: begin
                // STA reloads the address, STD lets the value rise
                dec.pop      = 1'b1;
                dec.load_stk = ~insn[1];
                dec.wr_stk1  = 1'b1;
                dec.wr_mem   = 1'b1;
                is_mem       = 1'b1;
              end
              default: dec.byt = 1'b0;
            endcase
          end
        end
        default: dec = '0;
      endcase
    end
  end

  // State updates land at execute, or at ack for memory instructions
  assign upd = (state == S_EXEC && !is_mem) || (state == S_MEM && ack);

  always_comb begin
    ctrl = dec;
    if (!upd) begin
      ctrl.pop      = 1'b0;
      ctrl.push     = 1'b0;
      ctrl.load_stk = 1'b0;
      ctrl.load_fp  = 1'b0;
      ctrl.load_ip  = 1'b0;
      ctrl.cpop     = 1'b0;
      ctrl.cpush    = 1'b0;
    end
    if (state == S_FETCH) begin
      // ip steps to the next word while the fetch completes
      ctrl           = '0;
      ctrl.src_a     = cpu_pkg::SRC_IP;
      ctrl.alu_op    = cpu_pkg::ALU_INC2;
      ctrl.load_ip   = ack;
      ctrl.load_insn = ack;
    end else if (state == S_IDLE) begin
      ctrl = '0;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE:  state <= S_FETCH;
        S_FETCH: if (ack) state <= S_EXEC;
        S_EXEC:  state <= is_mem ? S_MEM : S_FETCH;
        S_MEM:   if (ack) state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  assign bus_cyc   = (state == S_FETCH) || (state == S_MEM);
  assign bus_fetch = (state == S_FETCH);

endmodule

`default_nettype wire

// File: hw/stack.sv
`timescale 1ns/1ps
`default_nettype none

module stack #(
  parameter int STACK_DEPTH = 8
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        pop,
  input  logic        push,
  input  logic        load,
  input  logic [15:0] data_in,
  output logic [15:0] data0,
  output logic [15:0] data1
);

  logic [15:0] entry [STACK_DEPTH];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < STACK_DEPTH; i++) begin
        entry[i] <= '0;
      end
    end else if (push) begin
      // Shift down, oldest entry falls off the bottom
      for (int i = 1; i < STACK_DEPTH; i++) begin
        entry[i] <= entry[i-1];
      end
      if (load) begin
        entry[0] <= data_in;
      end
    end else if (pop) begin
      // Shift up, bottom refills with zero
      for (int i = 0; i < STACK_DEPTH - 1; i++) begin
        entry[i] <= entry[i+1];
      end
      entry[STACK_DEPTH-1] <= '0;
      // Pop with load replaces the new top
      if (load) begin
        entry[0] <= data_in;
      end
    end else if (load) begin
      entry[0] <= data_in;
    end
  end

  assign data0 = entry[0];
  assign data1 = entry[1];

endmodule

`default_nettype wire

// File: hw/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  logic [15:0]     a,
  input  logic [15:0]     b,
  input  logic            cond,
  input  cpu_pkg::alu_op_t op,
  output logic [15:0]     out
);

  logic [15:0] target;
  logic        taken;

  // ip already points past the branch, so step back one word
  // to make the offset relative to the branch itself
  assign target = a + b - 16'd2;

  // cond is high when stack0 is nonzero
  always_comb begin
    case (op)
      cpu_pkg::ALU_BRZ:  taken = ~cond;
      cpu_pkg::ALU_BRNZ: taken = cond;
      default:           taken = 1'b1;
    endcase
  end

  always_comb begin
    case (op)
      cpu_pkg::ALU_PASS_A: out = a;
      cpu_pkg::ALU_INC:    out = a + 16'd1;
      cpu_pkg::ALU_INC2:   out = a + 16'd2;
      cpu_pkg::ALU_NOT:    out = ~a;
      cpu_pkg::ALU_PASS_B: out = b;
      cpu_pkg::ALU_AND:    out = a & b;
      cpu_pkg::ALU_OR:     out = a | b;
      cpu_pkg::ALU_XOR:    out = a ^ b;
      cpu_pkg::ALU_SHR:    out = a >> b;
      cpu_pkg::ALU_SAR:    out = $signed(a) >>> b;
      cpu_pkg::ALU_SHL:    out = a << b;
      // High byte from b, low byte from a
      cpu_pkg::ALU_JOIN:   out = a | (b << 8);
      cpu_pkg::ALU_ADD:    out = a + b;
      cpu_pkg::ALU_SUB:    out = a - b;
      // Low half of the product only
      cpu_pkg::ALU_MUL:    out = a * b;
      cpu_pkg::ALU_LT:     out = {15'd0, $signed(a) < $signed(b)};
      cpu_pkg::ALU_EQ:     out = {15'd0, a == b};
      cpu_pkg::ALU_NEQ:    out = {15'd0, a != b};
      cpu_pkg::ALU_BR,
      cpu_pkg::ALU_BRZ,
      cpu_pkg::ALU_BRNZ:   out = taken ? target : a;
      // Unused codes leave stack0 as it is
      default:             out = a;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  // Byte address width, memory map 000h to FFFh
  localparam int ADDR_WIDTH = 12;

  // First instruction fetched after reset
  localparam logic [15:0] RESET_IP = 16'h0300;

  // Built-in functions live at and below this address
  localparam logic [ADDR_WIDTH-1:0] INTERNAL_LIMIT = 12'h07F;
  localparam logic [ADDR_WIDTH-1:0] TIMER_ADDR = 12'h002;

  // Wishbone classic request, byte addressed
  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [ADDR_WIDTH-1:0] adr;
    logic [1:0]            sel;
    logic [15:0]           dat;
  } wb_req_t;

  typedef struct packed {
    logic [15:0] dat;
    logic        ack;
  } wb_rsp_t;

  // Low codes match bits 5..0 of the stack ALU instructions
  // Branch codes only come from the immediate format
  typedef enum logic [5:0] {
    ALU_PASS_A = 6'h00,
    ALU_INC    = 6'h01,
    ALU_INC2   = 6'h02,
    ALU_NOT    = 6'h04,
    ALU_PASS_B = 6'h0f,
    ALU_AND    = 6'h10,
    ALU_OR     = 6'h11,
    ALU_XOR    = 6'h12,
    ALU_SHR    = 6'h14,
    ALU_SAR    = 6'h15,
    ALU_SHL    = 6'h16,
    ALU_JOIN   = 6'h17,
    ALU_ADD    = 6'h20,
    ALU_SUB    = 6'h21,
    ALU_MUL    = 6'h22,
    ALU_LT     = 6'h28,
    ALU_EQ     = 6'h29,
    ALU_NEQ    = 6'h2a,
    ALU_BR     = 6'h30,
    ALU_BRZ    = 6'h31,
    ALU_BRNZ   = 6'h32
  } alu_op_t;

  // Same order as the X field of LD, ST and PUSH
  typedef enum logic [1:0] {
    SRC_STK0 = 2'd0,
    SRC_FP   = 2'd1,
    SRC_IP   = 2'd2,
    SRC_CSTK = 2'd3
  } src_a_t;

  typedef struct packed {
    logic    imm;
    src_a_t  src_a;
    alu_op_t alu_op;
    logic    wr_stk1;
    logic    pop;
    logic    push;
    logic    load_stk;
    logic    load_fp;
    logic    load_ip;
    logic    load_insn;
    logic    cpop;
    logic    cpush;
    logic    byt;
    logic    rd_mem;
    logic    wr_mem;
  } ctrl_t;

endpackage

`default_nettype wire
